/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_WIDTH 32
`define REG_COUNT 16
`define MEM_DEPTH 512

// Each register field of the IR sits four bits below the previous one
`define OPC_MSB 31
`define RA_MSB (`OPC_MSB - 5)
`define RB_MSB (`RA_MSB - 4)
`define RC_MSB (`RB_MSB - 4)
`define CONST_WIDTH 19

`endif

/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        SHR,
        SHRA,
        SHL,
        ROR,
        ROL,
        MUL,
        DIV,
        NEG,
        NOT
    } aluOp_t;

    // Values that can drive the shared bus, in priority order after NONE
    typedef enum logic [2:0] {
        NONE,
        GPR,
        PC,
        MDR,
        ZHIGH,
        ZLOW,
        INPORT,
        CONST
    } busSrc_t;

endpackage

`default_nettype wire

/* design/busSourcesIf.sv */
`default_nettype none

`include "cpu_defs.svh"

interface busSourcesIf import cpuPkg::*; ();

    logic [`WORD_WIDTH-1:0] regValue;
    logic [`WORD_WIDTH-1:0] constValue;
    logic [`WORD_WIDTH-1:0] pcValue;
    logic [`WORD_WIDTH-1:0] inPortValue;
    logic [`WORD_WIDTH-1:0] mdrValue;
    logic [`WORD_WIDTH-1:0] zHighValue;
    logic [`WORD_WIDTH-1:0] zLowValue;

    // Source currently granted the bus
    busSrc_t selected;

    modport regFile (output regValue, output constValue);
    modport special (output pcValue, output inPortValue);
    modport memory (output mdrValue);
    modport alu (output zHighValue, output zLowValue);
    modport mux (
        input  regValue,
        input  constValue,
        input  pcValue,
        input  inPortValue,
        input  mdrValue,
        input  zHighValue,
        input  zLowValue,
        output selected
    );

endinterface

`default_nettype wire

/* design/registerFile.sv */
`default_nettype none

`include "cpu_defs.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic [`WORD_WIDTH-1:0] bus,
    input  logic [`WORD_WIDTH-1:0] ir,
    input  logic                   gra,
    input  logic                   grb,
    input  logic                   grc,
    input  logic                   rIn,
    input  logic                   rOut,
    input  logic                   baOut,
    busSourcesIf.regFile           src
);

    localparam int IdxWidth = $clog2(`REG_COUNT);

    logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];
    logic [IdxWidth-1:0]    regSel;
    logic [`REG_COUNT-1:0]  regLoad;

    // Gated IR fields are ORed, so only one of gra/grb/grc should be high
    always_comb begin
        regSel = ({IdxWidth{gra}} & ir[`RA_MSB -: IdxWidth])
               | ({IdxWidth{grb}} & ir[`RB_MSB -: IdxWidth])
               | ({IdxWidth{grc}} & ir[`RC_MSB -: IdxWidth]);
    end

    // Decode the index into one-hot load enables
    always_comb begin
        regLoad = '0;
        regLoad[regSel] = rIn;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // R0 reads as zero when used as a base address
    always_comb begin
        if (baOut && regSel == '0) begin
            src.regValue = '0;
        end else if (rOut || baOut) begin
            src.regValue = regs[regSel];
        end else begin
            src.regValue = '0;
        end
    end

    assign src.constValue = {{(`WORD_WIDTH - `CONST_WIDTH){ir[`CONST_WIDTH-1]}},
                             ir[`CONST_WIDTH-1:0]};

endmodule

`default_nettype wire

/* design/specialRegisters.sv */
`default_nettype none

`include "cpu_defs.svh"

module specialRegisters (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   pcIn,
    input  logic                   incPc,
    input  logic                   irIn,
    input  logic                   outPortIn,
    input  logic [`WORD_WIDTH-1:0] bus,
    input  logic [`WORD_WIDTH-1:0] inPortData,
    output logic [`WORD_WIDTH-1:0] outPortData,
    output logic [`WORD_WIDTH-1:0] ir,
    busSourcesIf.special           src
);

    logic [`WORD_WIDTH-1:0] pcReg;
    logic [`WORD_WIDTH-1:0] irReg;
    logic [`WORD_WIDTH-1:0] outPortReg;
    logic [`WORD_WIDTH-1:0] inPortReg;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pcReg      <= '0;
            irReg      <= '0;
            outPortReg <= '0;
        end else begin
            // incPc only matters together with pcIn
            if (pcIn) begin
                pcReg <= incPc ? pcReg + 1'b1 : bus;
            end
            if (irIn) begin
                irReg <= bus;
            end
            if (outPortIn) begin
                outPortReg <= bus;
            end
        end
    end

    // Input port is sampled every cycle
    always_ff @(posedge Clock) begin
        inPortReg <= inPortData;
    end

    assign ir              = irReg;
    assign outPortData     = outPortReg;
    assign src.pcValue     = pcReg;
    assign src.inPortValue = inPortReg;

endmodule

`default_nettype wire

/* design/memoryUnit.sv */
`default_nettype none

`include "cpu_defs.svh"

module memoryUnit (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   read,
    input  logic                   write,
    input  logic [`WORD_WIDTH-1:0] bus,
    busSourcesIf.memory            src
);

    localparam int AddrWidth = $clog2(`MEM_DEPTH);

    logic [AddrWidth-1:0]   marReg;
    logic [`WORD_WIDTH-1:0] mdrReg;
    logic [`WORD_WIDTH-1:0] mdrNext;
    logic [`WORD_WIDTH-1:0] readData;
    logic [`WORD_WIDTH-1:0] ram [`MEM_DEPTH];

    // Only the low address bits of the bus reach MAR
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (marIn) begin
                marReg <= bus[AddrWidth-1:0];
            end
            if (mdrIn) begin
                mdrReg <= mdrNext;
            end
        end
    end

    assign readData = ram[marReg];

    // MDR takes memory data on read and the bus otherwise
    assign mdrNext = read ? readData : bus;

    always_ff @(posedge Clock) begin
        if (write) begin
            ram[marReg] <= mdrReg;
        end
    end

    assign src.mdrValue = mdrReg;

endmodule

`default_nettype wire

/* design/aluUnit.sv */
`default_nettype none

`include "cpu_defs.svh"

module aluUnit import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   yIn,
    input  logic                   zIn,
    input  aluOp_t                 opcode,
    input  logic [`WORD_WIDTH-1:0] bus,
    busSourcesIf.alu               src
);

    localparam int W = `WORD_WIDTH;

    logic signed [W-1:0]   opA;
    logic signed [W-1:0]   opB;
    logic [$clog2(W)-1:0]  shamt;
    logic [2*W-1:0]        rotRight;
    logic [2*W-1:0]        rotLeft;
    logic signed [2*W-1:0] product;
    logic [W-1:0]          quotient;
    logic [W-1:0]          remainder;
    logic [W-1:0]          lowWord;
    logic [W-1:0]          highWord;
    logic                  wideOp;
    logic [2*W-1:0]        aluResult;
    logic [W-1:0]          yReg;
    logic [2*W-1:0]        zReg;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yIn) begin
                yReg <= bus;
            end
            if (zIn) begin
                zReg <= aluResult;
            end
        end
    end

    assign opA   = yReg;
    assign opB   = bus;
    assign shamt = opB[$clog2(W)-1:0];

    // Rotates through a doubled copy of A
    assign rotRight = {opA, opA} >> shamt;
    assign rotLeft  = {opA, opA} << shamt;
    assign product  = opA * opB;

    // Divide by zero gives all ones and leaves A as remainder
    always_comb begin
        if (opB == '0) begin
            quotient  = '1;
            remainder = opA;
        end else begin
            quotient  = opA / opB;
            remainder = opA % opB;
        end
    end

    always_comb begin
        lowWord  = '0;
        highWord = '0;
        wideOp   = 1'b0;
        case (opcode)
            ADD:  lowWord = opA + opB;
            SUB:  lowWord = opA - opB;
            AND:  lowWord = opA & opB;
            OR:   lowWord = opA | opB;
            SHR:  lowWord = opA >> shamt;
            SHRA: lowWord = opA >>> shamt;
            SHL:  lowWord = opA << shamt;
            ROR:  lowWord = rotRight[W-1:0];
            ROL:  lowWord = rotLeft[2*W-1:W];
            MUL: begin
                wideOp   = 1'b1;
                lowWord  = product[W-1:0];
                highWord = product[2*W-1:W];
            end
            DIV: begin
                wideOp   = 1'b1;
                lowWord  = quotient;
                highWord = remainder;
            end
            NEG:  lowWord = -opB;
            NOT:  lowWord = ~opB;
            default: lowWord = '0;
        endcase
    end

    // Single-word results are sign extended into Z high
    assign aluResult = {wideOp ? highWord : {W{lowWord[W-1]}}, lowWord};

    assign src.zHighValue = zReg[2*W-1:W];
    assign src.zLowValue  = zReg[W-1:0];

endmodule

`default_nettype wire

/* design/busMux.sv */
`default_nettype none

`include "cpu_defs.svh"

module busMux import cpuPkg::*; (
    input  logic                   gprOut,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    busSourcesIf.mux               src,
    output logic [`WORD_WIDTH-1:0] bus
);

    // Fixed priority in case more than one strobe is high
    always_comb begin
        if (gprOut) begin
            src.selected = GPR;
        end else if (pcOut) begin
            src.selected = PC;
        end else if (mdrOut) begin
            src.selected = MDR;
        end else if (zHighOut) begin
            src.selected = ZHIGH;
        end else if (zLowOut) begin
            src.selected = ZLOW;
        end else if (inPortOut) begin
            src.selected = INPORT;
        end else if (cOut) begin
            src.selected = CONST;
        end else begin
            src.selected = NONE;
        end
    end

    always_comb begin
        case (src.selected)
            GPR:     bus = src.regValue;
            PC:      bus = src.pcValue;
            MDR:     bus = src.mdrValue;
            ZHIGH:   bus = src.zHighValue;
            ZLOW:    bus = src.zLowValue;
            INPORT:  bus = src.inPortValue;
            CONST:   bus = src.constValue;
            default: bus = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

`include "cpu_defs.svh"

module datapath import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   gprOut,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    input  logic                   baOut,
    input  logic                   gra,
    input  logic                   grb,
    input  logic                   grc,
    input  logic                   rIn,
    input  logic                   pcIn,
    input  logic                   incPc,
    input  logic                   irIn,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   read,
    input  logic                   write,
    input  logic                   yIn,
    input  logic                   zIn,
    input  logic                   outPortIn,
    input  aluOp_t                 opcode,
    input  logic [`WORD_WIDTH-1:0] inPortData,
    output logic [`WORD_WIDTH-1:0] outPortData,
    output logic [`WORD_WIDTH-1:0] busValue
);

    logic [`WORD_WIDTH-1:0] bus;
    logic [`WORD_WIDTH-1:0] irWord;

    busSourcesIf sources ();

    // baOut also puts the selected register on the bus
    busMux u_busMux (
        .gprOut    (gprOut | baOut),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .inPortOut (inPortOut),
        .cOut      (cOut),
        .src       (sources.mux),
        .bus       (bus)
    );

    registerFile u_registerFile (
        .Clock (Clock),
        .arstN (arstN),
        .bus   (bus),
        .ir    (irWord),
        .gra   (gra),
        .grb   (grb),
        .grc   (grc),
        .rIn   (rIn),
        .rOut  (gprOut),
        .baOut (baOut),
        .src   (sources.regFile)
    );

    specialRegisters u_specialRegisters (
        .Clock       (Clock),
        .arstN       (arstN),
        .pcIn        (pcIn),
        .incPc       (incPc),
        .irIn        (irIn),
        .outPortIn   (outPortIn),
        .bus         (bus),
        .inPortData  (inPortData),
        .outPortData (outPortData),
        .ir          (irWord),
        .src         (sources.special)
    );

    memoryUnit u_memoryUnit (
        .Clock (Clock),
        .arstN (arstN),
        .marIn (marIn),
        .mdrIn (mdrIn),
        .read  (read),
        .write (write),
        .bus   (bus),
        .src   (sources.memory)
    );

    aluUnit u_aluUnit (
        .Clock  (Clock),
        .arstN  (arstN),
        .yIn    (yIn),
        .zIn    (zIn),
        .opcode (opcode),
        .bus    (bus),
        .src    (sources.alu)
    );

    assign busValue = bus;

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`default_nettype none

module clockGen (
    output logic Clock,
    output logic arstN
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Reset held low over the first two rising edges
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge Clock);
        #1 arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/datapath_chk.sv */
`default_nettype none

`include "cpu_defs.svh"

module datapath_chk (
    input logic                   Clock,
    input logic                   arstN,
    input logic                   gprOut,
    input logic                   pcOut,
    input logic                   mdrOut,
    input logic                   zHighOut,
    input logic                   zLowOut,
    input logic                   inPortOut,
    input logic                   cOut,
    input logic                   read,
    input logic                   write,
    input logic [`WORD_WIDTH-1:0] outPortData
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [6:0] outStrobes;

    assign outStrobes = {gprOut, pcOut, mdrOut, zHighOut, zLowOut, inPortOut, cOut};

    strobesOneHot: assert property (@(posedge Clock) disable iff (!arstN)
        $onehot0(outStrobes))
        else $error("More than one bus out strobe is high");

    // The RAM has a single port
    noReadWrite: assert property (@(posedge Clock) disable iff (!arstN)
        !(read && write))
        else $error("read and write are high in the same cycle");

    outPortCleared: assert property (@(posedge Clock)
        $rose(arstN) |-> outPortData == '0)
        else $error("Output port is not zero after reset");

endmodule

`default_nettype wire

/* testbench/datapathTb.sv */
`default_nettype none

`include "cpu_defs.svh"

module datapathTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `WORD_WIDTH;
    localparam int NumRegTests = 8;
    localparam int NumMemTests = 6;

    // Cycles spent by each sequence
    localparam int ResetCycles = 4 + `REG_COUNT * 3;
    localparam int RegCycles   = NumRegTests * 5;
    localparam int MemCycles   = NumMemTests * 9;
    localparam int AluCycles   = 14 * 6;
    localparam int FetchCycles = 17;
    localparam int CycleLimit  = 2 * (ResetCycles + RegCycles + MemCycles
                                      + AluCycles + FetchCycles);

    logic         Clock;
    logic         arstN;
    logic         gprOut;
    logic         pcOut;
    logic         mdrOut;
    logic         zHighOut;
    logic         zLowOut;
    logic         inPortOut;
    logic         cOut;
    logic         baOut;
    logic         gra;
    logic         grb;
    logic         grc;
    logic         rIn;
    logic         pcIn;
    logic         incPc;
    logic         irIn;
    logic         marIn;
    logic         mdrIn;
    logic         read;
    logic         write;
    logic         yIn;
    logic         zIn;
    logic         outPortIn;
    aluOp_t       opcode;
    logic [W-1:0] inPortData;
    logic [W-1:0] outPortData;
    logic [W-1:0] busValue;

    // Reference model state
    logic [W-1:0]   modelRegs [`REG_COUNT];
    logic [W-1:0]   modelRam [`MEM_DEPTH];
    logic [W-1:0]   modelPc;
    logic [W-1:0]   modelY;
    logic [2*W-1:0] modelZ;

    logic [31:0] seed = 32'd2;
    int checkCount = 0;
    int failCount = 0;
    int testChecks = 0;
    int testFails = 0;
    int cycleCount = 0;

    clockGen u_clockGen (
        .Clock (Clock),
        .arstN (arstN)
    );

    datapath i_dut (.*);

    bind datapath datapath_chk u_chk (
        .Clock       (Clock),
        .arstN       (arstN),
        .gprOut      (gprOut),
        .pcOut       (pcOut),
        .mdrOut      (mdrOut),
        .zHighOut    (zHighOut),
        .zLowOut     (zLowOut),
        .inPortOut   (inPortOut),
        .cOut        (cOut),
        .read        (read),
        .write       (write),
        .outPortData (outPortData)
    );

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Expected 64-bit Z for one operation, A from Y and B from the bus
    function automatic logic [2*W-1:0] expectedAlu(aluOp_t op, logic [W-1:0] a,
                                                   logic [W-1:0] b);
        logic [4:0]          s;
        logic [W-1:0]        lo;
        logic signed [W-1:0] sa;
        logic signed [W-1:0] sb;
        logic signed [2*W-1:0] prod;
        logic [2*W-1:0]      result;
        s = b[4:0];
        sa = a;
        sb = b;
        lo = '0;
        case (op)
            ADD:  lo = a + b;
            SUB:  lo = a - b;
            AND:  lo = a & b;
            OR:   lo = a | b;
            SHR:  lo = a >> s;
            SHRA: lo = sa >>> s;
            SHL:  lo = a << s;
            ROR:  lo = (s == 0) ? a : (a >> s) | (a << (32 - s));
            ROL:  lo = (s == 0) ? a : (a << s) | (a >> (32 - s));
            NEG:  lo = -b;
            NOT:  lo = ~b;
            default: lo = '0;
        endcase
        result = {{W{lo[W-1]}}, lo};
        if (op == MUL) begin
            prod = sa * sb;
            result = prod;
        end else if (op == DIV) begin
            if (b == '0) begin
                result = {a, {W{1'b1}}};
            end else begin
                result = {sa % sb, sa / sb};
            end
        end
        return result;
    endfunction

    task automatic idleControls();
        {gprOut, pcOut, mdrOut, zHighOut, zLowOut, inPortOut, cOut, baOut} = '0;
        {gra, grb, grc, rIn, pcIn, incPc, irIn, marIn, mdrIn} = '0;
        {read, write, yIn, zIn, outPortIn} = '0;
        opcode = ADD;
    endtask

    // One microstep ends at the next rising edge
    task automatic step();
        @(posedge Clock);
        #1;
        idleControls();
    endtask

    task automatic checkWord(input string name, input logic [W-1:0] actual,
                             input logic [W-1:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            failCount++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkBus(input logic [W-1:0] expected);
        #1;
        checkWord("busValue", busValue, expected);
    endtask

    // Input port latches one edge after the data is driven
    task automatic presentInput(input logic [W-1:0] value);
        inPortData = value;
        step();
    endtask

    task automatic loadIr(input logic [W-1:0] value);
        presentInput(value);
        inPortOut = 1'b1;
        irIn = 1'b1;
        step();
    endtask

    task automatic writeMemory(input logic [W-1:0] addr, input logic [W-1:0] data);
        presentInput(addr);
        inPortOut = 1'b1;
        marIn = 1'b1;
        step();
        presentInput(data);
        inPortOut = 1'b1;
        mdrIn = 1'b1;
        step();
        write = 1'b1;
        step();
        modelRam[addr[8:0]] = data;
    endtask

    task automatic finishTest(input string name);
        $display("%s: %0d checks, %0d failed", name, checkCount - testChecks,
                 failCount - testFails);
        testChecks = checkCount;
        testFails = failCount;
    endtask

    task automatic runReset();
        zLowOut = 1'b1;
        checkBus(modelZ[W-1:0]);
        step();
        zHighOut = 1'b1;
        checkBus(modelZ[2*W-1:W]);
        step();
        for (int r = 0; r < `REG_COUNT; r++) begin
            loadIr(W'(r) << (`RA_MSB - 3));
            gra = 1'b1;
            gprOut = 1'b1;
            checkBus(modelRegs[r]);
            step();
        end
    endtask

    task automatic runRegisters();
        logic [3:0]   r;
        logic [W-1:0] value;
        for (int n = 0; n < NumRegTests; n++) begin
            r = nextRand() >> 28;
            value = nextRand();
            loadIr(W'(r) << (`RA_MSB - 3));
            presentInput(value);
            inPortOut = 1'b1;
            gra = 1'b1;
            rIn = 1'b1;
            step();
            modelRegs[r] = value;
            gra = 1'b1;
            gprOut = 1'b1;
            outPortIn = 1'b1;
            checkBus(modelRegs[r]);
            step();
            checkWord("outPortData", outPortData, modelRegs[r]);
        end
    endtask

    task automatic runMemory();
        logic [W-1:0] addrs [$];
        logic [W-1:0] addr;
        for (int n = 0; n < NumMemTests; n++) begin
            addr = nextRand();
            addrs.push_back(addr);
            writeMemory(addr, nextRand());
        end
        foreach (addrs[i]) begin
            presentInput(addrs[i]);
            inPortOut = 1'b1;
            marIn = 1'b1;
            step();
            read = 1'b1;
            mdrIn = 1'b1;
            step();
            mdrOut = 1'b1;
            checkBus(modelRam[addrs[i][8:0]]);
            step();
        end
    endtask

    task automatic runAlu(input aluOp_t op, input logic [W-1:0] a, input logic [W-1:0] b);
        presentInput(a);
        inPortOut = 1'b1;
        yIn = 1'b1;
        step();
        modelY = a;
        presentInput(b);
        inPortOut = 1'b1;
        zIn = 1'b1;
        opcode = op;
        step();
        modelZ = expectedAlu(op, modelY, b);
        zLowOut = 1'b1;
        checkBus(modelZ[W-1:0]);
        step();
        zHighOut = 1'b1;
        checkBus(modelZ[2*W-1:W]);
        step();
    endtask

    task automatic runFetch();
        logic [W-1:0] instr;
        logic [W-1:0] pc;
        logic [W-1:0] constWord;
        logic [W-1:0] r0Value;
        // Rb cleared so that baOut selects R0
        instr = nextRand() & ~(32'hF << (`RB_MSB - 3));
        pc = nextRand();
        constWord = {{(W - `CONST_WIDTH){instr[`CONST_WIDTH-1]}}, instr[`CONST_WIDTH-1:0]};
        writeMemory(pc, instr);
        presentInput(pc);
        inPortOut = 1'b1;
        pcIn = 1'b1;
        step();
        modelPc = pc;
        pcOut = 1'b1;
        marIn = 1'b1;
        incPc = 1'b1;
        pcIn = 1'b1;
        checkBus(modelPc);
        step();
        modelPc = modelPc + 1;
        read = 1'b1;
        mdrIn = 1'b1;
        step();
        mdrOut = 1'b1;
        irIn = 1'b1;
        checkBus(modelRam[pc[8:0]]);
        step();
        pcOut = 1'b1;
        checkBus(modelPc);
        step();
        cOut = 1'b1;
        checkBus(constWord);
        step();
        // R0 holds a nonzero value so that the baOut zeroing is visible
        r0Value = nextRand() | 32'h1;
        presentInput(r0Value);
        inPortOut = 1'b1;
        grb = 1'b1;
        rIn = 1'b1;
        step();
        modelRegs[0] = r0Value;
        grb = 1'b1;
        baOut = 1'b1;
        yIn = 1'b1;
        checkBus('0);
        step();
        modelY = '0;
        cOut = 1'b1;
        zIn = 1'b1;
        opcode = ADD;
        step();
        modelZ = expectedAlu(ADD, modelY, constWord);
        zLowOut = 1'b1;
        checkBus(modelZ[W-1:0]);
        step();
    endtask

    // Ends a hung run
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Run did not finish within %0d cycles", CycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        idleControls();
        inPortData = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        modelPc = '0;
        modelY = '0;
        modelZ = '0;
        wait (arstN === 1'b1);
        step();
        runReset();
        finishTest("Reset");
        runRegisters();
        finishTest("Register load and read-back");
        runMemory();
        finishTest("Memory");
        for (int k = 0; k <= int'(NOT); k++) begin
            runAlu(aluOp_t'(k), nextRand(), nextRand());
        end
        runAlu(DIV, nextRand(), '0);
        finishTest("ALU");
        runFetch();
        finishTest("Fetch and immediate");
        $display("Summary: %0d checks, %0d failed", checkCount, failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/cpuPkg.sv
design/busSourcesIf.sv
design/registerFile.sv
design/specialRegisters.sv
design/memoryUnit.sv
design/aluUnit.sv
design/busMux.sv
design/datapath.sv
testbench/clockGen.sv
testbench/datapath_chk.sv
testbench/datapathTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module datapathTb -f list.f -o datapathSim

./obj_dir/datapathSim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
